//--- sim.f
+incdir+source
source/axi_lite64_pkg.sv
source/core_bus_pkg.sv
source/bus_router.sv
source/clint_timer.sv
source/serial_tx_port.sv
source/core_bus_top.sv
sim/axi_mem_model.sv
sim/tb_core_bus.sv

//--- Bender.yml
package:
  name: core_bus

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/axi_lite64_pkg.sv
      - source/core_bus_pkg.sv
      - source/bus_router.sv
      - source/clint_timer.sv
      - source/serial_tx_port.sv
      - source/core_bus_top.sv

  - target: simulation
    include_dirs:
      - source
    files:
      - sim/axi_mem_model.sv
      - sim/tb_core_bus.sv

//--- sim/tb_core_bus.sv
`include "bus_params.svh"

module tb_core_bus
  import core_bus_pkg::*, axi_lite64_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned TIMEOUT   = 200;
  localparam int unsigned MEM_WORDS = 256;
  localparam int unsigned REF_WORDS = 512;
  localparam int unsigned MTIME_GAP = 20;
  localparam int unsigned RSP_FETCH = 0;
  localparam int unsigned RSP_LOAD  = 1;
  localparam int unsigned RSP_STORE = 2;
  localparam addr_t       MEM_BASE  = 32'h8000_0000;

  logic        clk;
  logic        rst;
  fetch_req_t  fetch;
  load_req_t   load;
  store_req_t  store;
  rsp_t        fetch_rsp;
  rsp_t        load_rsp;
  logic        store_done;
  axi_ar_t     axi_ar;
  logic        axi_arvalid;
  logic        axi_arready;
  axi_r_t      axi_r;
  logic        axi_rvalid;
  axi_aw_t     axi_aw;
  logic        axi_awvalid;
  logic        axi_awready;
  axi_w_t      axi_w;
  logic        axi_wvalid;
  logic        axi_wready;
  axi_b_t      axi_b;
  logic        axi_bvalid;
  logic [7:0]  tx_byte;
  logic        tx_valid;
  logic [31:0] mem_writes;

  // expected memory contents, one entry per 32-bit word
  word_t       ref_mem [REF_WORDS];
  int unsigned error_count;
  int unsigned timeout_count;
  int unsigned tx_count;
  logic [7:0]  tx_last;
  axi_size_t   ar_size_last;
  axi_size_t   aw_size_last;

  core_bus_top dut_i (
    .clk           (clk),
    .rst           (rst),
    .fetch_i       (fetch),
    .load_i        (load),
    .store_i       (store),
    .fetch_rsp_o   (fetch_rsp),
    .load_rsp_o    (load_rsp),
    .store_done_o  (store_done),
    .axi_ar_o      (axi_ar),
    .axi_arvalid_o (axi_arvalid),
    .axi_arready_i (axi_arready),
    .axi_r_i       (axi_r),
    .axi_rvalid_i  (axi_rvalid),
    .axi_aw_o      (axi_aw),
    .axi_awvalid_o (axi_awvalid),
    .axi_awready_i (axi_awready),
    .axi_w_o       (axi_w),
    .axi_wvalid_o  (axi_wvalid),
    .axi_wready_i  (axi_wready),
    .axi_b_i       (axi_b),
    .axi_bvalid_i  (axi_bvalid),
    .tx_byte_o     (tx_byte),
    .tx_valid_o    (tx_valid)
  );

  axi_mem_model mem_i (
    .clk           (clk),
    .rst           (rst),
    .ar_i          (axi_ar),
    .arvalid_i     (axi_arvalid),
    .arready_o     (axi_arready),
    .r_o           (axi_r),
    .rvalid_o      (axi_rvalid),
    .aw_i          (axi_aw),
    .awvalid_i     (axi_awvalid),
    .awready_o     (axi_awready),
    .w_i           (axi_w),
    .wvalid_i      (axi_wvalid),
    .wready_o      (axi_wready),
    .b_o           (axi_b),
    .bvalid_o      (axi_bvalid),
    .write_count_o (mem_writes)
  );

  always #5 clk = ~clk;

  // serial output monitor
  always @(negedge clk)
  begin
    if (!rst && tx_valid)
    begin
      tx_count++;
      tx_last = tx_byte;
    end
  end

  // sizes of the last accepted AXI address beats
  always @(posedge clk)
  begin
    if (axi_arvalid && axi_arready)
      ar_size_last <= axi_ar.size;
    if (axi_awvalid && axi_awready)
      aw_size_last <= axi_aw.size;
  end

  // rotated address mixed with a constant
  function automatic word_t fill_word(input addr_t addr);
    return addr ^ {addr[7:0], addr[31:8]} ^ 32'h3c5a_96e1;
  endfunction

  function automatic int unsigned ref_index(input addr_t addr);
    return int'(addr[10:2]);
  endfunction

  function automatic word_t merge_lanes(input word_t old, input word_t data, input byte_en_t be);
    word_t res;
    int    k;
    res = old;
    for (k = 0; k < 4; k++)
      if (be[k])
        res[8*k +: 8] = data[8*k +: 8];
    return res;
  endfunction

  // log2 of the number of enabled byte lanes
  function automatic axi_size_t lanes_to_size(input byte_en_t be);
    int lanes;
    int size;
    int k;
    lanes = 0;
    for (k = 0; k < 4; k++)
      if (be[k])
        lanes++;
    size = 0;
    while ((1 << size) < lanes)
      size++;
    return axi_size_t'(size);
  endfunction

  function automatic logic rsp_seen(input int unsigned which);
    logic seen;
    case (which)
      RSP_FETCH: seen = fetch_rsp.valid;
      RSP_LOAD:  seen = load_rsp.valid;
      default:   seen = store_done;
    endcase
    return seen;
  endfunction

  task automatic report_failure(input string test, input string what);
    error_count++;
    $display("[ERROR] %s: %s", test, what);
  endtask

  task automatic check_word(input string test, input word_t expected, input word_t actual);
    assert (actual == expected)
    else
    begin
      error_count++;
      $display("[ERROR] %s: expected %08h, actual %08h", test, expected, actual);
    end
  endtask

  task automatic preload_memory();
    int    i;
    addr_t lo_addr;
    for (i = 0; i < MEM_WORDS; i++)
    begin
      lo_addr = MEM_BASE + addr_t'(i * 8);
      ref_mem[2*i]   = fill_word(lo_addr);
      ref_mem[2*i+1] = fill_word(lo_addr + 32'd4);
      mem_i.mem[i]   = {ref_mem[2*i+1], ref_mem[2*i]};
    end
  endtask

  // cycles counts falling edges from the request to the response
  task automatic wait_response(input string test, input int unsigned which,
                               output word_t data, output int unsigned cycles);
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
      seen = rsp_seen(which);
    end
    data = (which == RSP_FETCH) ? fetch_rsp.data : load_rsp.data;
    assert (seen)
    else
    begin
      timeout_count++;
      report_failure(test, $sformatf("no response within %0d cycles", TIMEOUT));
    end
  endtask

  task automatic fetch_word(input string test, input addr_t addr, output word_t data);
    int unsigned cycles;
    @(negedge clk);
    fetch.valid = 1'b1;
    fetch.addr  = addr;
    wait_response(test, RSP_FETCH, data, cycles);
    fetch.valid = 1'b0;
  endtask

  task automatic load_word(input string test, input addr_t addr,
                           output word_t data, output int unsigned cycles);
    @(negedge clk);
    load.valid   = 1'b1;
    load.addr    = addr;
    load.byte_en = 4'hf;
    wait_response(test, RSP_LOAD, data, cycles);
    load.valid = 1'b0;
  endtask

  task automatic store_lanes(input string test, input addr_t addr, input word_t data,
                             input byte_en_t be, output int unsigned cycles);
    word_t unused;
    @(negedge clk);
    store.valid   = 1'b1;
    store.addr    = addr;
    store.data    = data;
    store.byte_en = be;
    wait_response(test, RSP_STORE, unused, cycles);
    store.valid = 1'b0;
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    assert (!(axi_arvalid || axi_awvalid || axi_wvalid))
    else
      report_failure("reset_state", "an AXI valid is high after reset");
    assert (!(fetch_rsp.valid || load_rsp.valid || store_done || tx_valid))
    else
      report_failure("reset_state", "a response or tx valid is high after reset");
  endtask

  task automatic test_timer();
    word_t       hi;
    word_t       first;
    word_t       second;
    int unsigned cycles;
    load_word("timer_hi", `BUS_MTIME_HI_ADDR, hi, cycles);
    check_word("timer_hi", 32'h0, hi);
    check_word("timer_hi_latency", 32'd2, word_t'(cycles));
    load_word("timer_lo", `BUS_MTIME_LO_ADDR, first, cycles);
    check_word("timer_lo_latency", 32'd2, word_t'(cycles));
    repeat (MTIME_GAP) @(negedge clk);
    load_word("timer_lo", `BUS_MTIME_LO_ADDR, second, cycles);
    check_word("timer_lo_latency", 32'd2, word_t'(cycles));
    assert (second - first >= word_t'(MTIME_GAP))
    else
    begin
      error_count++;
      $display("[ERROR] timer_delta: expected at least %0d, actual %0d",
               MTIME_GAP, second - first);
    end
  endtask

  // consecutive words cover both 64-bit halves
  task automatic test_fetch_lanes();
    int    i;
    addr_t addr;
    word_t data;
    for (i = 0; i < 16; i++)
    begin
      addr = MEM_BASE + 32'h100 + addr_t'(i * 4);
      fetch_word("fetch_lanes", addr, data);
      check_word("fetch_lanes", ref_mem[ref_index(addr)], data);
    end
  endtask

  task automatic test_load_over_fetch(input addr_t load_addr, input addr_t fetch_addr);
    word_t       load_data;
    word_t       fetch_data;
    logic        got_load;
    logic        got_fetch;
    logic        fetch_first;
    int unsigned cycles;
    @(negedge clk);
    load.valid   = 1'b1;
    load.addr    = load_addr;
    load.byte_en = 4'hf;
    fetch.valid  = 1'b1;
    fetch.addr   = fetch_addr;
    got_load    = 1'b0;
    got_fetch   = 1'b0;
    fetch_first = 1'b0;
    cycles      = 0;
    while (!(got_load && got_fetch) && cycles < TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
      if (load_rsp.valid && !got_load)
      begin
        got_load   = 1'b1;
        load_data  = load_rsp.data;
        load.valid = 1'b0;
      end
      if (fetch_rsp.valid && !got_fetch)
      begin
        fetch_first = !got_load;
        got_fetch   = 1'b1;
        fetch_data  = fetch_rsp.data;
        fetch.valid = 1'b0;
      end
    end
    load.valid  = 1'b0;
    fetch.valid = 1'b0;
    assert (got_load && got_fetch)
    else
    begin
      timeout_count++;
      report_failure("load_over_fetch", "load or fetch response missing after timeout");
    end
    assert (!fetch_first)
    else
      report_failure("load_over_fetch", "fetch response came before the load response");
    if (got_load)
      check_word("load_over_fetch_load", ref_mem[ref_index(load_addr)], load_data);
    if (got_fetch)
      check_word("load_over_fetch_fetch", ref_mem[ref_index(fetch_addr)], fetch_data);
  endtask

  task automatic store_then_load(input string test, input addr_t addr,
                                 input word_t data, input byte_en_t be);
    logic [31:0] writes_before;
    word_t       readback;
    int unsigned cycles;
    writes_before = mem_writes;
    store_lanes(test, addr, data, be, cycles);
    check_word({test, "_aw_size"}, word_t'(lanes_to_size(be)), word_t'(aw_size_last));
    ref_mem[ref_index(addr)] = merge_lanes(ref_mem[ref_index(addr)], data, be);
    load_word(test, addr, readback, cycles);
    check_word(test, ref_mem[ref_index(addr)], readback);
    check_word({test, "_ar_size"}, word_t'(lanes_to_size(4'hf)), word_t'(ar_size_last));
    check_word({test, "_axi_writes"}, writes_before + 32'd1, mem_writes);
  endtask

  task automatic test_serial();
    logic [31:0] writes_before;
    int unsigned tx_before;
    int unsigned cycles;
    writes_before = mem_writes;
    tx_before     = tx_count;
    store_lanes("serial", `BUS_SERIAL_ADDR, 32'h1234_56a7, 4'b0001, cycles);
    check_word("serial_latency", 32'd1, word_t'(cycles));
    assert (tx_valid)
    else
      report_failure("serial", "tx_valid is low in the store_done cycle");
    // let the monitor see the strobe
    repeat (3) @(negedge clk);
    check_word("serial_tx_count", 32'd1, word_t'(tx_count - tx_before));
    check_word("serial_tx_byte", 32'h0000_00a7, word_t'(tx_last));
    check_word("serial_axi_writes", writes_before, mem_writes);
  endtask

  initial
  begin
    clk           = 1'b0;
    rst           = 1'b1;
    fetch         = '0;
    load          = '0;
    store         = '0;
    error_count   = 0;
    timeout_count = 0;
    tx_count      = 0;
    tx_last       = '0;
    preload_memory();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset_state();
    test_timer();
    test_fetch_lanes();
    test_load_over_fetch(MEM_BASE + 32'h040, MEM_BASE + 32'h084);
    test_load_over_fetch(MEM_BASE + 32'h0cc, MEM_BASE + 32'h0d0);
    test_load_over_fetch(MEM_BASE + 32'h134, MEM_BASE + 32'h13c);
    store_then_load("store_byte", MEM_BASE + 32'h200, 32'hdead_beef, 4'b0010);
    store_then_load("store_half", MEM_BASE + 32'h20c, 32'hcafe_f00d, 4'b1100);
    store_then_load("store_word", MEM_BASE + 32'h214, 32'h0bad_c0de, 4'b1111);
    store_then_load("store_low_half", MEM_BASE + 32'h218, 32'h5566_7788, 4'b0011);
    test_serial();

    $display("summary: %0d errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- sim/axi_mem_model.sv
module axi_mem_model
  import axi_lite64_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  axi_ar_t     ar_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output axi_r_t      r_o,
  output logic        rvalid_o,
  input  axi_aw_t     aw_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  axi_w_t      w_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output axi_b_t      b_o,
  output logic        bvalid_o,
  output logic [31:0] write_count_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MEM_WORDS = 256;

  // 64-bit words, filled by the testbench before reset ends
  axi_data_t mem [MEM_WORDS];

  logic [31:0] lfsr_q;
  logic [1:0]  ar_cnt;
  logic [1:0]  r_cnt;
  logic [1:0]  aw_cnt;
  logic [1:0]  w_cnt;
  logic [1:0]  b_cnt;
  logic        ar_armed;
  logic        aw_armed;
  logic        w_armed;
  logic        r_pend;
  logic        b_pend;
  logic        aw_got;
  logic        w_got;
  axi_addr_t   rd_addr;
  axi_addr_t   wr_addr;
  axi_w_t      wr_beat;

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ 32'h8020_0003;
    else
      return state >> 1;
  endfunction

  // one lfsr step per delay bit
  task automatic draw_delay(output logic [1:0] delay);
    int k;
    for (k = 0; k < 2; k++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      delay[k] = lfsr_q[0];
    end
  endtask

  task automatic write_beat();
    int k;
    int idx;
    idx = int'(wr_addr[10:3]);
    for (k = 0; k < 8; k++)
      if (wr_beat.strb[k])
        mem[idx][8*k +: 8] = wr_beat.data[8*k +: 8];
  endtask

  always @(posedge clk)
  begin
    if (rst)
    begin
      lfsr_q   = 32'hc607_be6b;
      ar_armed = 1'b0;
      aw_armed = 1'b0;
      w_armed  = 1'b0;
      r_pend   = 1'b0;
      b_pend   = 1'b0;
      aw_got   = 1'b0;
      w_got    = 1'b0;
      arready_o     <= 1'b0;
      awready_o     <= 1'b0;
      wready_o      <= 1'b0;
      rvalid_o      <= 1'b0;
      bvalid_o      <= 1'b0;
      r_o           <= '0;
      b_o           <= '0;
      write_count_o <= '0;
    end
    else
    begin
      arready_o <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      rvalid_o  <= 1'b0;
      bvalid_o  <= 1'b0;

      // read address, ready after a random wait
      if (arvalid_i && arready_o)
      begin
        rd_addr  = ar_i.addr;
        ar_armed = 1'b0;
        r_pend   = 1'b1;
        draw_delay(r_cnt);
      end
      else if (arvalid_i && !r_pend)
      begin
        if (!ar_armed)
        begin
          draw_delay(ar_cnt);
          ar_armed = 1'b1;
        end
        if (ar_cnt == 2'd0)
          arready_o <= 1'b1;
        else
          ar_cnt = ar_cnt - 2'd1;
      end
      if (r_pend)
      begin
        if (r_cnt == 2'd0)
        begin
          r_o.data <= mem[int'(rd_addr[10:3])];
          r_o.resp <= AXI_RESP_OKAY;
          rvalid_o <= 1'b1;
          r_pend = 1'b0;
        end
        else
          r_cnt = r_cnt - 2'd1;
      end

      // write address and data accepted independently
      if (awvalid_i && awready_o)
      begin
        wr_addr  = aw_i.addr;
        aw_got   = 1'b1;
        aw_armed = 1'b0;
        write_count_o <= write_count_o + 32'd1;
      end
      else if (awvalid_i && !aw_got)
      begin
        if (!aw_armed)
        begin
          draw_delay(aw_cnt);
          aw_armed = 1'b1;
        end
        if (aw_cnt == 2'd0)
          awready_o <= 1'b1;
        else
          aw_cnt = aw_cnt - 2'd1;
      end
      if (wvalid_i && wready_o)
      begin
        wr_beat = w_i;
        w_got   = 1'b1;
        w_armed = 1'b0;
      end
      else if (wvalid_i && !w_got)
      begin
        if (!w_armed)
        begin
          draw_delay(w_cnt);
          w_armed = 1'b1;
        end
        if (w_cnt == 2'd0)
          wready_o <= 1'b1;
        else
          w_cnt = w_cnt - 2'd1;
      end

      // both halves in, commit and schedule the response
      if (aw_got && w_got && !b_pend)
      begin
        write_beat();
        aw_got = 1'b0;
        w_got  = 1'b0;
        b_pend = 1'b1;
        draw_delay(b_cnt);
      end
      if (b_pend)
      begin
        if (b_cnt == 2'd0)
        begin
          b_o.resp <= AXI_RESP_OKAY;
          bvalid_o <= 1'b1;
          b_pend = 1'b0;
        end
        else
          b_cnt = b_cnt - 2'd1;
      end
    end
  end

endmodule

//--- source/core_bus_top.sv
module core_bus_top
  import core_bus_pkg::*, axi_lite64_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  fetch_req_t fetch_i,
  input  load_req_t  load_i,
  input  store_req_t store_i,
  output rsp_t       fetch_rsp_o,
  output rsp_t       load_rsp_o,
  output logic       store_done_o,
  output axi_ar_t    axi_ar_o,
  output logic       axi_arvalid_o,
  input  logic       axi_arready_i,
  input  axi_r_t     axi_r_i,
  input  logic       axi_rvalid_i,
  output axi_aw_t    axi_aw_o,
  output logic       axi_awvalid_o,
  input  logic       axi_awready_i,
  output axi_w_t     axi_w_o,
  output logic       axi_wvalid_o,
  input  logic       axi_wready_i,
  input  axi_b_t     axi_b_i,
  input  logic       axi_bvalid_i,
  output logic [7:0] tx_byte_o,
  output logic       tx_valid_o
);

  // router to local devices
  mtime_rd_t  mtime_rd;
  rsp_t       mtime_rsp;
  serial_wr_t serial_wr;

  bus_router router_i (
    .clk           (clk),
    .rst           (rst),
    .fetch_i       (fetch_i),
    .load_i        (load_i),
    .store_i       (store_i),
    .fetch_rsp_o   (fetch_rsp_o),
    .load_rsp_o    (load_rsp_o),
    .store_done_o  (store_done_o),
    .mtime_rd_o    (mtime_rd),
    .mtime_rsp_i   (mtime_rsp),
    .serial_wr_o   (serial_wr),
    .axi_ar_o      (axi_ar_o),
    .axi_arvalid_o (axi_arvalid_o),
    .axi_arready_i (axi_arready_i),
    .axi_r_i       (axi_r_i),
    .axi_rvalid_i  (axi_rvalid_i),
    .axi_aw_o      (axi_aw_o),
    .axi_awvalid_o (axi_awvalid_o),
    .axi_awready_i (axi_awready_i),
    .axi_w_o       (axi_w_o),
    .axi_wvalid_o  (axi_wvalid_o),
    .axi_wready_i  (axi_wready_i),
    .axi_b_i       (axi_b_i),
    .axi_bvalid_i  (axi_bvalid_i)
  );

  clint_timer timer_i (
    .clk   (clk),
    .rst   (rst),
    .rd_i  (mtime_rd),
    .rsp_o (mtime_rsp)
  );

  serial_tx_port serial_i (
    .clk        (clk),
    .rst        (rst),
    .wr_i       (serial_wr),
    .tx_byte_o  (tx_byte_o),
    .tx_valid_o (tx_valid_o)
  );

endmodule

//--- source/serial_tx_port.sv
module serial_tx_port
  import core_bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  serial_wr_t wr_i,
  output logic [7:0] tx_byte_o,
  output logic       tx_valid_o
);

  logic [7:0] tx_byte_q;
  logic       tx_valid_q;

  // one strobe per accepted write
  always_ff @(posedge clk)
  begin
    if (rst)
      tx_valid_q <= 1'b0;
    else
      tx_valid_q <= wr_i.valid;
  end

  always_ff @(posedge clk)
  begin
    if (wr_i.valid)
      tx_byte_q <= wr_i.data;
  end

  assign tx_byte_o  = tx_byte_q;
  assign tx_valid_o = tx_valid_q;

  // router spends a cycle in ST_B after each serial store
  a_no_back_to_back: assert property (@(posedge clk) disable iff (rst)
    wr_i.valid |=> !wr_i.valid);

endmodule

//--- source/clint_timer.sv
module clint_timer
  import core_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  mtime_rd_t rd_i,
  output rsp_t      rsp_o
);

  mtime_t mtime_q;
  logic   rsp_valid_q;
  word_t  rsp_data_q;

  // free-running, no compare
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime_q <= '0;
    else
      mtime_q <= mtime_q + mtime_t'(1);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      rsp_valid_q <= 1'b0;
    else
      rsp_valid_q <= rd_i.valid;
  end

  // value seen in the request cycle
  always_ff @(posedge clk)
  begin
    if (rd_i.valid)
    begin
      if (rd_i.hi)
        rsp_data_q <= mtime_q[63:32];
      else
        rsp_data_q <= mtime_q[31:0];
    end
  end

  assign rsp_o.valid = rsp_valid_q;
  assign rsp_o.data  = rsp_data_q;

endmodule

//--- source/bus_router.sv
`include "bus_params.svh"

module bus_router
  import core_bus_pkg::*, axi_lite64_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  fetch_req_t fetch_i,
  input  load_req_t  load_i,
  input  store_req_t store_i,
  output rsp_t       fetch_rsp_o,
  output rsp_t       load_rsp_o,
  output logic       store_done_o,
  output mtime_rd_t  mtime_rd_o,
  input  rsp_t       mtime_rsp_i,
  output serial_wr_t serial_wr_o,
  output axi_ar_t    axi_ar_o,
  output logic       axi_arvalid_o,
  input  logic       axi_arready_i,
  input  axi_r_t     axi_r_i,
  input  logic       axi_rvalid_i,
  output axi_aw_t    axi_aw_o,
  output logic       axi_awvalid_o,
  input  logic       axi_awready_i,
  output axi_w_t     axi_w_o,
  output logic       axi_wvalid_o,
  input  logic       axi_wready_i,
  input  axi_b_t     axi_b_i,
  input  logic       axi_bvalid_i
);

  router_state_e state_q;

  addr_t    req_addr_q;
  word_t    req_data_q;
  byte_en_t req_be_q;
  logic     mtime_hi_q;

  // read owner, load when set, else fetch
  logic req_load_q;
  // served by timer or serial port
  logic req_local_q;
  logic aw_done_q;
  logic w_done_q;
  logic mtime_rd_valid_q;

  logic      store_serial;
  logic      load_mtime;
  logic      aw_fire;
  logic      w_fire;
  logic      read_done;
  word_t     read_data;
  axi_size_t req_size;

  function automatic axi_size_t size_from_be(input byte_en_t be);
    axi_size_t size;
    case (be)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: size = 3'd0;
      4'b0011, 4'b1100:                   size = 3'd1;
      default:                            size = 3'd2;
    endcase
    return size;
  endfunction

  // address decode of the incoming requests
  assign store_serial = store_i.addr == addr_t'(`BUS_SERIAL_ADDR);
  assign load_mtime   = (load_i.addr == addr_t'(`BUS_MTIME_LO_ADDR)) ||
                        (load_i.addr == addr_t'(`BUS_MTIME_HI_ADDR));

  assign aw_fire = axi_awvalid_o && axi_awready_i;
  assign w_fire  = axi_wvalid_o && axi_wready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q          <= ST_IDLE;
      req_load_q       <= 1'b0;
      req_local_q      <= 1'b0;
      aw_done_q        <= 1'b0;
      w_done_q         <= 1'b0;
      mtime_rd_valid_q <= 1'b0;
    end
    else
    begin
      mtime_rd_valid_q <= 1'b0;
      case (state_q)
        ST_IDLE:
        begin
          aw_done_q <= 1'b0;
          w_done_q  <= 1'b0;
          // store beats load, load beats fetch
          if (store_i.valid)
          begin
            req_local_q <= store_serial;
            state_q     <= store_serial ? ST_B : ST_AW_W;
          end
          else if (load_i.valid)
          begin
            req_load_q       <= 1'b1;
            req_local_q      <= load_mtime;
            mtime_rd_valid_q <= load_mtime;
            state_q          <= load_mtime ? ST_R : ST_AR;
          end
          else if (fetch_i.valid)
          begin
            req_load_q  <= 1'b0;
            req_local_q <= 1'b0;
            state_q     <= ST_AR;
          end
        end
        ST_AR:
        begin
          if (axi_arready_i)
            state_q <= ST_R;
        end
        ST_R:
        begin
          if (read_done)
            state_q <= ST_IDLE;
        end
        ST_AW_W:
        begin
          aw_done_q <= aw_done_q || aw_fire;
          w_done_q  <= w_done_q || w_fire;
          if ((aw_done_q || aw_fire) && (w_done_q || w_fire))
            state_q <= ST_B;
        end
        ST_B:
        begin
          // serial store finishes here without waiting
          if (req_local_q || axi_bvalid_i)
            state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // request payload, captured when leaving idle
  always_ff @(posedge clk)
  begin
    if (state_q == ST_IDLE)
    begin
      mtime_hi_q <= load_i.addr == addr_t'(`BUS_MTIME_HI_ADDR);
      if (store_i.valid)
      begin
        req_addr_q <= store_i.addr;
        req_data_q <= store_i.data;
        req_be_q   <= store_i.byte_en;
      end
      else if (load_i.valid)
      begin
        req_addr_q <= load_i.addr;
        req_be_q   <= load_i.byte_en;
      end
      else
      begin
        req_addr_q <= fetch_i.addr;
        req_be_q   <= '1;
      end
    end
  end

  assign req_size = size_from_be(req_be_q);

  assign mtime_rd_o.valid = mtime_rd_valid_q;
  assign mtime_rd_o.hi    = mtime_hi_q;

  // serial port takes the byte in the decode cycle
  assign serial_wr_o.valid = (state_q == ST_IDLE) && store_i.valid && store_serial;
  assign serial_wr_o.data  = store_i.data[7:0];

  assign axi_arvalid_o = state_q == ST_AR;
  assign axi_ar_o.addr = req_addr_q;
  assign axi_ar_o.size = req_size;

  assign axi_awvalid_o = (state_q == ST_AW_W) && !aw_done_q;
  assign axi_aw_o.addr = req_addr_q;
  assign axi_aw_o.size = req_size;

  // addr bit 2 selects the upper 32-bit lane
  assign axi_wvalid_o = (state_q == ST_AW_W) && !w_done_q;
  assign axi_w_o.data = req_addr_q[2] ? {req_data_q, word_t'(0)} : {word_t'(0), req_data_q};
  assign axi_w_o.strb = req_addr_q[2] ? {req_be_q, byte_en_t'(0)} : {byte_en_t'(0), req_be_q};

  assign read_done = (state_q == ST_R) && (req_local_q ? mtime_rsp_i.valid : axi_rvalid_i);
  assign read_data = req_local_q ? mtime_rsp_i.data :
                     req_addr_q[2] ? axi_r_i.data[63:32] : axi_r_i.data[31:0];

  assign fetch_rsp_o.valid = read_done && !req_load_q;
  assign fetch_rsp_o.data  = read_data;
  assign load_rsp_o.valid  = read_done && req_load_q;
  assign load_rsp_o.data   = read_data;

  assign store_done_o = (state_q == ST_B) && (req_local_q || axi_bvalid_i);

  // the memory side never reports an error here
  a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
    axi_rvalid_i |-> axi_r_i.resp == AXI_RESP_OKAY);

  a_bresp_okay: assert property (@(posedge clk) disable iff (rst)
    axi_bvalid_i |-> axi_b_i.resp == AXI_RESP_OKAY);

  a_one_read_rsp: assert property (@(posedge clk) disable iff (rst)
    !(fetch_rsp_o.valid && load_rsp_o.valid));

endmodule

//--- source/core_bus_pkg.sv
`include "bus_params.svh"

package core_bus_pkg;

  typedef logic [`BUS_DATA_W-1:0]   word_t;
  typedef logic [`BUS_ADDR_W-1:0]   addr_t;
  typedef logic [`BUS_DATA_W/8-1:0] byte_en_t;
  typedef logic [2*`BUS_DATA_W-1:0] mtime_t;

  // core requests hold until their response
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    logic     valid;
    addr_t    addr;
    byte_en_t byte_en;
  } load_req_t;

  typedef struct packed {
    logic     valid;
    addr_t    addr;
    word_t    data;
    byte_en_t byte_en;
  } store_req_t;

  // fetch and load responses share this
  typedef struct packed {
    logic  valid;
    word_t data;
  } rsp_t;

  // router to timer
  typedef struct packed {
    logic valid;
    logic hi;
  } mtime_rd_t;

  // router to serial port
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } serial_wr_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_AR,
    ST_R,
    ST_AW_W,
    ST_B
  } router_state_e;

endpackage

//--- source/axi_lite64_pkg.sv
`include "bus_params.svh"

package axi_lite64_pkg;

  // single-beat AXI4 subset, no ids, no bursts
  typedef logic [`BUS_ADDR_W-1:0]       axi_addr_t;
  typedef logic [`BUS_AXI_DATA_W-1:0]   axi_data_t;
  typedef logic [`BUS_AXI_DATA_W/8-1:0] axi_strb_t;

  // log2 of bytes per beat
  typedef logic [2:0] axi_size_t;
  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

  typedef struct packed {
    axi_addr_t addr;
    axi_size_t size;
  } axi_ar_t;

  typedef struct packed {
    axi_data_t data;
    axi_resp_t resp;
  } axi_r_t;

  typedef struct packed {
    axi_addr_t addr;
    axi_size_t size;
  } axi_aw_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
  } axi_w_t;

  typedef struct packed {
    axi_resp_t resp;
  } axi_b_t;

endpackage

//--- source/bus_params.svh
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// core side widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// external memory port, two 32-bit lanes
`define BUS_AXI_DATA_W 64

// write-only serial port, one byte per store
`define BUS_SERIAL_ADDR 32'h1000_0000

// clint mtime, low and high word
`define BUS_MTIME_LO_ADDR 32'h0200_BFF8
`define BUS_MTIME_HI_ADDR 32'h0200_BFFC

`endif
